// File: maze_consts.svh
`ifndef MAZE_CONSTS_SVH
`define MAZE_CONSTS_SVH

// ------------------------------
// grid geometry
// ------------------------------

// cells per side of the square grid
`define MAZE_N 16
// row or column index width
`define MAZE_CW 4

// ------------------------------
// weights and cost
// ------------------------------

// per-cell weight loaded by the host
`define MAZE_WW 4
// path cost accumulator
// 16*16 cells of weight 15 still fit in 12 bits
`define MAZE_COSTW 12

// two-bit cell codes written by the host or by retrace
// codes 2 and 3 are the wave marks and only the ripple writes them
`define CELL_EMPTY 2'd0
`define CELL_BLOCK 2'd1

`endif

// File: maze_pkg.sv
`include "maze_consts.svh"

package maze_pkg;

	// ------------------------------
	// vector types
	// ------------------------------
	typedef logic [`MAZE_CW-1:0]    coord_t;
	typedef logic [`MAZE_WW-1:0]    weight_t;
	typedef logic [`MAZE_COSTW-1:0] cost_t;
	typedef logic [1:0]             cell_t;

	// one entry per column, column 0 sits in the low bits
	typedef logic [`MAZE_N-1:0]          row_bits_t;
	typedef logic [`MAZE_N*`MAZE_WW-1:0] row_weights_t;
	typedef logic [`MAZE_N*2-1:0]        row_cells_t;

	// controller states
	typedef enum logic [2:0] {
		IDLE,
		SEED,
		RIPPLE,
		RETRACE,
		CLEAR
	} ctrl_state_t;

	// ------------------------------
	// bundles
	// ------------------------------
	typedef struct packed {
		coord_t row;
		coord_t col;
	} loc_t;

	typedef struct packed {
		loc_t source;
		loc_t sink;
	} net_t;

	// broadcast to every row each cycle
	typedef struct packed {
		logic         load;
		coord_t       load_row;
		row_bits_t    load_blocked;
		row_weights_t load_weights;
		logic         seed;
		loc_t         seed_loc;
		// sink cell is cleared together with the source seed
		loc_t         sink_loc;
		logic         expand;
		cell_t        mark;
		logic         clear;
	} row_cmd_t;

	// mark one cell as routed
	typedef struct packed {
		logic valid;
		loc_t loc;
	} path_wr_t;

endpackage

// File: wave_row.sv
`include "maze_consts.svh"

module wave_row #(
	parameter int ROW = 0
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  maze_pkg::row_cmd_t     cmd,
	// cell codes of rows ROW-1 and ROW+1
	input  maze_pkg::row_cells_t   above,
	input  maze_pkg::row_cells_t   below,
	input  maze_pkg::path_wr_t     path_wr,
	output maze_pkg::row_cells_t   cells,
	output maze_pkg::row_weights_t weights
);

	// out-of-grid rows never count as marked
	localparam bit HAS_ABOVE = (ROW > 0);
	localparam bit HAS_BELOW = (ROW < `MAZE_N - 1);
	// source code at distance 0
	localparam maze_pkg::cell_t SRC_MARK = 2'd2;

	maze_pkg::row_cells_t   cells_q, cells_nxt;
	maze_pkg::row_weights_t weights_q;
	// bit 1 of a code is set only for wave marks
	maze_pkg::row_bits_t    own_mark, up_mark, down_mark, nbr_mark;
	logic                   row_hit_load, row_hit_path, row_hit_seed, row_hit_sink;

	// ------------------------------
	// row decode
	// ------------------------------
	assign row_hit_load = cmd.load && (cmd.load_row == maze_pkg::coord_t'(ROW));
	assign row_hit_path = path_wr.valid && (path_wr.loc.row == maze_pkg::coord_t'(ROW));
	assign row_hit_seed = cmd.seed && (cmd.seed_loc.row == maze_pkg::coord_t'(ROW));
	assign row_hit_sink = cmd.seed && (cmd.sink_loc.row == maze_pkg::coord_t'(ROW));

	// ------------------------------
	// neighbour marks
	// ------------------------------
	always_comb begin
		for (int c = 0; c < `MAZE_N; c++) begin
			own_mark[c]  = cells_q[2*c+1];
			up_mark[c]   = HAS_ABOVE && above[2*c+1];
			down_mark[c] = HAS_BELOW && below[2*c+1];
		end
	end

	// one-column shifts bring in left and right neighbours
	// zeros shift in at both row ends
	assign nbr_mark = (own_mark << 1) | (own_mark >> 1) | up_mark | down_mark;

	// ------------------------------
	// cell update
	// ------------------------------
	always_comb begin
		cells_nxt = cells_q;
		for (int c = 0; c < `MAZE_N; c++) begin
			if (row_hit_load) begin
				cells_nxt[2*c +: 2] = cmd.load_blocked[c] ? `CELL_BLOCK : `CELL_EMPTY;
			end else if (row_hit_path && (path_wr.loc.col == maze_pkg::coord_t'(c))) begin
				// routed cells block later nets
				cells_nxt[2*c +: 2] = `CELL_BLOCK;
			end else if (row_hit_seed && (cmd.seed_loc.col == maze_pkg::coord_t'(c))) begin
				cells_nxt[2*c +: 2] = SRC_MARK;
			end else if (row_hit_sink && (cmd.sink_loc.col == maze_pkg::coord_t'(c))) begin
				// sink must be reachable even if loaded as blocked
				cells_nxt[2*c +: 2] = `CELL_EMPTY;
			end else if (cmd.expand && (cells_q[2*c +: 2] == `CELL_EMPTY) && nbr_mark[c]) begin
				cells_nxt[2*c +: 2] = cmd.mark;
			end else if (cmd.clear && own_mark[c]) begin
				// wipe the wave, keep blocks and routes
				cells_nxt[2*c +: 2] = `CELL_EMPTY;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cells_q <= {`MAZE_N{`CELL_EMPTY}};
		end else begin
			cells_q <= cells_nxt;
		end
	end

	// weights change only on a host load
	always_ff @(posedge clk) begin
		if (row_hit_load) begin
			weights_q <= cmd.load_weights;
		end
	end

	assign cells   = cells_q;
	assign weights = weights_q;

endmodule

// File: route_retrace.sv
`include "maze_consts.svh"

module route_retrace (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 go,
	input  maze_pkg::net_t                       cur_net,
	// mark of the distance one step nearer the source
	input  maze_pkg::cell_t                      seek_mark,
	input  maze_pkg::row_cells_t   [`MAZE_N-1:0] grid_cells,
	input  maze_pkg::row_weights_t [`MAZE_N-1:0] grid_weights,
	output maze_pkg::path_wr_t                   path_wr,
	output logic                                 at_source,
	output logic                                 sink_reached,
	output maze_pkg::cost_t                      cost
);

	localparam maze_pkg::coord_t EDGE = maze_pkg::coord_t'(`MAZE_N - 1);

	logic              active;
	maze_pkg::loc_t    pos, next_loc;
	maze_pkg::coord_t  row_dn, row_up, col_rt, col_lf;
	maze_pkg::cell_t   cell_dn, cell_up, cell_rt, cell_lf;
	logic              found;
	maze_pkg::weight_t step_weight;

	// the wave has arrived once the sink code is a mark
	assign sink_reached = grid_cells[cur_net.sink.row][2*cur_net.sink.col+1];

	// ------------------------------
	// neighbour fetch
	// ------------------------------
	assign row_dn = pos.row + 1'b1;
	assign row_up = pos.row - 1'b1;
	assign col_rt = pos.col + 1'b1;
	assign col_lf = pos.col - 1'b1;

	// wrapped indices are masked by the edge checks below
	assign cell_dn = grid_cells[row_dn][2*pos.col +: 2];
	assign cell_up = grid_cells[row_up][2*pos.col +: 2];
	assign cell_rt = grid_cells[pos.row][2*col_rt +: 2];
	assign cell_lf = grid_cells[pos.row][2*col_lf +: 2];

	// ------------------------------
	// step select
	// ------------------------------
	// priority down, up, right, left
	always_comb begin
		next_loc = pos;
		found    = 1'b1;
		if ((pos.row != EDGE) && (cell_dn == seek_mark)) begin
			next_loc.row = row_dn;
		end else if ((pos.row != '0) && (cell_up == seek_mark)) begin
			next_loc.row = row_up;
		end else if ((pos.col != EDGE) && (cell_rt == seek_mark)) begin
			next_loc.col = col_rt;
		end else if ((pos.col != '0) && (cell_lf == seek_mark)) begin
			next_loc.col = col_lf;
		end else begin
			found = 1'b0;
		end
	end

	assign step_weight = grid_weights[next_loc.row][`MAZE_WW*next_loc.col +: `MAZE_WW];

	// sink is marked on go and every new cell on its step
	always_comb begin
		path_wr.valid = go || (active && found);
		path_wr.loc   = go ? cur_net.sink : next_loc;
	end

	// last step lands on the source
	assign at_source = active && found && (next_loc == cur_net.source);

	// ------------------------------
	// walk state and cost
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			cost   <= '0;
		end else if (go) begin
			active <= 1'b1;
			cost   <= '0;
		end else if (active && found) begin
			// sink weight never enters since the walk starts past it
			cost <= cost + maze_pkg::cost_t'(step_weight);
			if (at_source) begin
				active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (go) begin
			pos <= cur_net.sink;
		end else if (active) begin
			pos <= next_loc;
		end
	end

	// the wavefront left by the rows must always offer an in-grid step
	a_step_in_grid: assert property (@(posedge clk) disable iff (!rst_n)
		active |-> found);

endmodule

// File: route_ctrl.sv
module route_ctrl (
	input  logic                   clk,
	input  logic                   rst_n,
	// host row load
	input  logic                   map_valid,
	input  maze_pkg::coord_t       map_row,
	input  maze_pkg::row_bits_t    map_blocked,
	input  maze_pkg::row_weights_t map_weights,
	// host net request
	input  logic                   start,
	input  maze_pkg::net_t         net,
	// status from the array and retrace
	input  logic                   sink_reached,
	input  logic                   at_source,
	output maze_pkg::row_cmd_t     cmd,
	output maze_pkg::net_t         cur_net,
	output maze_pkg::cell_t        seek_mark,
	output logic                   retrace_go,
	output logic                   busy,
	output logic                   done
);

	maze_pkg::ctrl_state_t state, state_nxt;
	// wavefront distance mod 4
	logic [1:0]            wave_cnt;
	maze_pkg::cell_t       wave_mark;
	logic                  start_ok;

	// requests only count in IDLE
	assign start_ok = start && (state == maze_pkg::IDLE);

	// ------------------------------
	// state machine
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= maze_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			maze_pkg::IDLE: begin
				if (start_ok) begin
					state_nxt = maze_pkg::SEED;
				end
			end
			// one cycle to plant the source
			maze_pkg::SEED: begin
				state_nxt = maze_pkg::RIPPLE;
			end
			// leave once the sink carries a mark
			maze_pkg::RIPPLE: begin
				if (sink_reached) begin
					state_nxt = maze_pkg::RETRACE;
				end
			end
			maze_pkg::RETRACE: begin
				if (at_source) begin
					state_nxt = maze_pkg::CLEAR;
				end
			end
			maze_pkg::CLEAR: begin
				state_nxt = maze_pkg::IDLE;
			end
			default: begin
				state_nxt = maze_pkg::IDLE;
			end
		endcase
	end

	// net is held for the whole run
	always_ff @(posedge clk) begin
		if (start_ok) begin
			cur_net <= net;
		end
	end

	// ------------------------------
	// wave counter
	// ------------------------------
	// distance d carries mark {1, d[1]} giving 2,2,3,3
	// the first expand writes distance 1
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wave_cnt <= 2'd0;
		end else begin
			case (state)
				maze_pkg::SEED: begin
					wave_cnt <= 2'd1;
				end
				maze_pkg::RIPPLE: begin
					// counter sits at sink distance plus one here
					// so back off two to seek the sink's predecessor
					if (sink_reached) begin
						wave_cnt <= wave_cnt - 2'd2;
					end else begin
						wave_cnt <= wave_cnt + 2'd1;
					end
				end
				// one distance closer to the source per step
				maze_pkg::RETRACE: begin
					wave_cnt <= wave_cnt - 2'd1;
				end
				default: begin
					wave_cnt <= wave_cnt;
				end
			endcase
		end
	end

	assign wave_mark = {1'b1, wave_cnt[1]};
	assign seek_mark = wave_mark;

	// ------------------------------
	// row commands
	// ------------------------------
	always_comb begin
		cmd.load         = map_valid && (state == maze_pkg::IDLE);
		cmd.load_row     = map_row;
		cmd.load_blocked = map_blocked;
		cmd.load_weights = map_weights;
		cmd.seed         = (state == maze_pkg::SEED);
		cmd.seed_loc     = cur_net.source;
		cmd.sink_loc     = cur_net.sink;
		// no expand on the cycle the sink is seen
		cmd.expand       = (state == maze_pkg::RIPPLE) && !sink_reached;
		cmd.mark         = wave_mark;
		cmd.clear        = (state == maze_pkg::CLEAR);
	end

	assign retrace_go = (state == maze_pkg::RIPPLE) && sink_reached;
	assign busy       = (state != maze_pkg::IDLE);

	// pulse on the return to IDLE
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else begin
			done <= (state == maze_pkg::CLEAR);
		end
	end

	// a start seen mid-run must not disturb the net being routed
	a_net_held: assert property (@(posedge clk) disable iff (!rst_n)
		(state != maze_pkg::IDLE) |=> $stable(cur_net));

	// done comes with the fall of busy and lasts one cycle
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $fell(busy) ##1 !done);

endmodule

// File: maze_router.sv
`include "maze_consts.svh"

module maze_router (
	input  logic                   clk,
	input  logic                   rst_n,
	// row load port
	input  logic                   map_valid,
	input  maze_pkg::coord_t       map_row,
	input  maze_pkg::row_bits_t    map_blocked,
	input  maze_pkg::row_weights_t map_weights,
	// net request port
	input  logic                   start,
	input  maze_pkg::net_t         net,
	output logic                   busy,
	output logic                   done,
	output maze_pkg::cost_t        cost
);

	// command fan-out from the controller
	maze_pkg::row_cmd_t cmd;
	maze_pkg::net_t     cur_net;
	maze_pkg::cell_t    seek_mark;
	logic               retrace_go;

	// retrace feedback
	maze_pkg::path_wr_t path_wr;
	logic               sink_reached;
	logic               at_source;

	// whole grid state, row r in slot r
	maze_pkg::row_cells_t   [`MAZE_N-1:0] grid_cells;
	maze_pkg::row_weights_t [`MAZE_N-1:0] grid_weights;

	// ------------------------------
	// feed
	// ------------------------------
	route_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.map_valid    (map_valid),
		.map_row      (map_row),
		.map_blocked  (map_blocked),
		.map_weights  (map_weights),
		.start        (start),
		.net          (net),
		.sink_reached (sink_reached),
		.at_source    (at_source),
		.cmd          (cmd),
		.cur_net      (cur_net),
		.seek_mark    (seek_mark),
		.retrace_go   (retrace_go),
		.busy         (busy),
		.done         (done)
	);

	// ------------------------------
	// row array
	// ------------------------------
	// edge rows get a dummy neighbour that they ignore by ROW
	for (genvar r = 0; r < `MAZE_N; r++) begin : g_row
		wave_row #(
			.ROW (r)
		) u_row (
			.clk     (clk),
			.rst_n   (rst_n),
			.cmd     (cmd),
			.above   (grid_cells[(r == 0) ? 0 : r - 1]),
			.below   (grid_cells[(r == `MAZE_N - 1) ? r : r + 1]),
			.path_wr (path_wr),
			.cells   (grid_cells[r]),
			.weights (grid_weights[r])
		);
	end

	// ------------------------------
	// drain
	// ------------------------------
	route_retrace u_retrace (
		.clk          (clk),
		.rst_n        (rst_n),
		.go           (retrace_go),
		.cur_net      (cur_net),
		.seek_mark    (seek_mark),
		.grid_cells   (grid_cells),
		.grid_weights (grid_weights),
		.path_wr      (path_wr),
		.at_source    (at_source),
		.sink_reached (sink_reached),
		.cost         (cost)
	);

endmodule

// File: tb_maze_router.sv
`include "maze_consts.svh"

module tb_maze_router;

	// ------------------------------
	// bench constants
	// ------------------------------
	localparam int MAX_RECS = 64;
	// cycles allowed from start to done
	localparam int TIMEOUT = 1000;

	// record opcodes in the top hex digit
	localparam logic [3:0] OP_END  = 4'h0;
	localparam logic [3:0] OP_ROW  = 4'h1;
	localparam logic [3:0] OP_FILL = 4'h2;
	localparam logic [3:0] OP_NET  = 4'h3;

	// net record flag bits
	localparam int FLAG_START = 0;
	localparam int FLAG_LOAD  = 1;

	logic                   clk;
	logic                   rst_n;
	logic                   map_valid;
	maze_pkg::coord_t       map_row;
	maze_pkg::row_bits_t    map_blocked;
	maze_pkg::row_weights_t map_weights;
	logic                   start;
	maze_pkg::net_t         net;
	logic                   busy;
	logic                   done;
	maze_pkg::cost_t        cost;

	// one record per line of the vector file
	logic [87:0] vec_mem [0:MAX_RECS-1];
	logic [87:0] rec;
	int          ptr;
	int          n_nets;
	// seed for $random
	integer      seed;

	maze_router u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.map_valid   (map_valid),
		.map_row     (map_row),
		.map_blocked (map_blocked),
		.map_weights (map_weights),
		.start       (start),
		.net         (net),
		.busy        (busy),
		.done        (done),
		.cost        (cost)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic abort_run();
		$display("Test failures found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			abort_run();
		end
	endtask

	// one row write, sampled at the following edge
	task automatic load_row(input maze_pkg::coord_t row, input maze_pkg::row_bits_t blk,
			input maze_pkg::row_weights_t wts);
		@(posedge clk);
		map_valid   <= 1'b1;
		map_row     <= row;
		map_blocked <= blk;
		map_weights <= wts;
	endtask

	// start one net, optionally disturb it, and wait for done
	task automatic run_net(input int idx, input maze_pkg::net_t n,
			input maze_pkg::cost_t exp_cost, input logic [3:0] flags);
		int             cycles;
		logic           got_done;
		maze_pkg::net_t dist_net;
		// sink one column over, so a rerouted net ends one step nearer or farther
		dist_net            = n;
		dist_net.sink.col[0] = ~n.sink.col[0];
		@(posedge clk);
		map_valid <= 1'b0;
		start     <= 1'b1;
		net       <= n;
		@(negedge clk);
		check_val("busy", busy, 1'b0);
		@(posedge clk);
		start <= 1'b0;
		// busy must be up one cycle after the start is taken
		@(negedge clk);
		check_val("busy", busy, 1'b1);
		check_val("done", done, 1'b0);
		cycles   = 0;
		got_done = 1'b0;
		while (!got_done) begin
			@(posedge clk);
			if (cycles == 0) begin
				// second request for a net of a different length
				if (flags[FLAG_START]) begin
					start <= 1'b1;
					net   <= dist_net;
				end
				// row write that would wall off the sink row
				if (flags[FLAG_LOAD]) begin
					map_valid   <= 1'b1;
					map_row     <= n.sink.row;
					map_blocked <= '1;
					map_weights <= '1;
				end
			end else if (cycles == 1) begin
				start     <= 1'b0;
				net       <= n;
				map_valid <= 1'b0;
			end
			@(negedge clk);
			cycles++;
			if (done) begin
				got_done = 1'b1;
			end else begin
				check_val("busy", busy, 1'b1);
				assert (cycles < TIMEOUT) else begin
					$display("net %0d: done did not arrive within %0d cycles", idx, TIMEOUT);
					abort_run();
				end
			end
		end
		// done arrives with busy already low
		check_val("busy", busy, 1'b0);
		check_val("cost", cost, exp_cost);
		@(negedge clk);
		check_val("done", done, 1'b0);
		check_val("cost", cost, exp_cost);
		$display("net %0d routed in %0d cycles, cost 0x%03h", idx, cycles, cost);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		seed        = 32'he41e_51e2;
		rst_n       = 1'b0;
		map_valid   = 1'b0;
		map_row     = '0;
		map_blocked = '0;
		map_weights = '0;
		start       = 1'b0;
		net         = '0;
		n_nets      = 0;
		$readmemh("maze_vectors.txt", vec_mem);

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_val("busy", busy, 1'b0);
		check_val("done", done, 1'b0);

		ptr = 0;
		rec = vec_mem[0];
		while (rec[87:84] !== OP_END) begin
			// a missing file or a bad line shows up as an unknown opcode
			assert (rec[87:84] inside {OP_ROW, OP_FILL, OP_NET}) else begin
				$display("vector record %0d has an unknown opcode", ptr);
				abort_run();
			end
			case (rec[87:84])
				OP_ROW: begin
					load_row(rec[83:80], rec[79:64], rec[63:0]);
				end
				// same row data into every row
				OP_FILL: begin
					for (int r = 0; r < `MAZE_N; r++) begin
						load_row(maze_pkg::coord_t'(r), rec[79:64], rec[63:0]);
					end
				end
				OP_NET: begin
					run_net(n_nets, maze_pkg::net_t'(rec[79:64]), rec[11:0], rec[83:80]);
					n_nets++;
				end
				default: begin
					n_nets = n_nets;
				end
			endcase
			ptr++;
			rec = vec_mem[ptr];
		end

		@(posedge clk);
		map_valid <= 1'b0;
		assert (n_nets > 0) else begin
			$display("the vector file holds no nets");
			abort_run();
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

// File: maze_vectors.txt
// columns: op(1) arg(1) field(4) data(16) hex digits, column 0 in the low digits
// op 1 row: arg row, blocked, weights; op 2 all rows; op 3 net: arg flags, net, cost
// net digits are src row, src col, sink row, sink col; flag 1 extra start, 2 extra load
//
// test 1 open grid with unit weights, cost is the Manhattan distance
2000001111111111111111
3123D90000000000000011
32F0FF000000000000000F
//
// test 2 wall in column 8 with a gap in row 15, weights vary by column
2001003141592653589793
1F00002222222222222222
30243C0000000000000068
//
// test 3 two nets in sequence, the second detours below the first path
2000001111111111111111
3005A5000000000000000A
3042480000000000000014
//
// end of vectors
0000000000000000000000

// File: maze_router.f
+incdir+.
maze_pkg.sv
wave_row.sv
route_retrace.sv
route_ctrl.sv
maze_router.sv
tb_maze_router.sv
